//--- cache_geom_pkg.sv
package cache_geom_pkg;

    // address split, tag | index | byte offset
    localparam int TAG_W    = 23;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;

    // organisation
    localparam int SETS = 64;
    localparam int WAYS = 2;

    // payload widths
    localparam int WORD_W = 32;
    localparam int LINE_W = 64;
    localparam int WORDS  = LINE_W / WORD_W;

    // lowest offset bit that picks a word inside the line
    localparam int WORD_SEL_LSB = $clog2(WORD_W / 8);

endpackage

//--- cache_types_pkg.sv
package cache_types_pkg;

    import cache_geom_pkg::*;

    // address fields
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [ADDR_W-1:0]   addr_t;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 (lower address) sits in the low half
    typedef word_t [WORDS-1:0] line_t;

    typedef logic [$clog2(WAYS)-1:0] way_t;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE
    } ctrl_state_t;

endpackage

//--- cache_ram.sv
`timescale 1ns/1ns

module cache_ram
    import cache_geom_pkg::*;
    import cache_types_pkg::*;
#(
    parameter type entry_t = line_t,
    parameter int  DEPTH   = SETS
) (
    input  logic   clk,
    input  index_t addr,
    input  logic   we,
    input  entry_t wdata,
    output entry_t rdata
);

    entry_t mem [DEPTH];

    // read every cycle, a write shows up on rdata right away
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- set_state.sv
`timescale 1ns/1ns

module set_state
    import cache_geom_pkg::*;
    import cache_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  index_t          addr,
    input  logic            touch,
    input  way_t            touch_way,
    input  logic            fill,
    output logic [WAYS-1:0] valid_ways,
    output way_t            victim_way
);

    logic [WAYS-1:0] valid_q [SETS];
    // least recently used way of each set
    way_t            lru_q   [SETS];

    logic [WAYS-1:0] valid_nxt;
    way_t            lru_nxt;
    way_t            used_way;

    // first invalid way, else the lru one
    function automatic way_t pick_victim(logic [WAYS-1:0] v, way_t lru);
        way_t w;
        w = lru;
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (!v[i]) begin
                w = way_t'(i);
            end
        end
        return w;
    endfunction

    // next state of the addressed set
    always_comb begin
        valid_nxt = valid_q[addr];
        lru_nxt   = lru_q[addr];
        used_way  = touch ? touch_way : victim_way;
        if (fill) begin
            valid_nxt[victim_way] = 1'b1;
        end
        if (touch || fill) begin
            lru_nxt = ~used_way;
        end
    end

    // outputs registered from the updated set, so a fill is seen next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                lru_q[s]   <= '0;
            end
            valid_ways <= '0;
            victim_way <= '0;
        end else begin
            valid_q[addr] <= valid_nxt;
            lru_q[addr]   <= lru_nxt;
            valid_ways    <= valid_nxt;
            victim_way    <= pick_victim(valid_nxt, lru_nxt);
        end
    end

    a_touch_fill_excl: assert property (@(posedge clk) disable iff (rst)
        !(touch && fill))
        else $error("touch and fill in the same cycle");

    // victim_way belongs to the set read one cycle earlier
    a_fill_same_set: assert property (@(posedge clk) disable iff (rst)
        fill |-> $stable(addr))
        else $error("fill while the set address moved");

endmodule

//--- icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl
    import cache_geom_pkg::*;
    import cache_types_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    // pipeline side
    input  logic            valid,
    input  index_t          index,
    input  tag_t            tag,
    input  offset_t         offset,
    output logic            addr_ok,
    output logic            data_ok,
    output word_t           rdata,
    // memory side
    output logic            rd_req,
    output addr_t           rd_addr,
    input  line_t           ret_data,
    // tag and data RAMs
    output index_t          ram_addr,
    output logic [WAYS-1:0] tag_we,
    output logic [WAYS-1:0] data_we,
    output tag_t            fill_tag,
    output line_t           fill_line,
    input  tag_t            way_tag [WAYS],
    input  line_t           way_line [WAYS],
    // set state
    input  logic [WAYS-1:0] valid_ways,
    input  way_t            victim_way,
    output logic            touch,
    output way_t            touch_way,
    output logic            fill
);

    ctrl_state_t state_q;
    ctrl_state_t state_nxt;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;

    logic [WAYS-1:0] way_hit;
    logic            hit;
    logic            lookup_hit;
    way_t            hit_way;
    word_t           hit_word;

    line_t           miss_line;
    logic [WAYS-1:0] fill_we;

    // request buffer, loaded on acceptance
    always_ff @(posedge clk) begin
        if (addr_ok && valid) begin
            req_tag    <= tag;
            req_index  <= index;
            req_offset <= offset;
        end
    end

    // new index goes straight to the RAMs while idle
    assign ram_addr = (state_q == IDLE) ? index : req_index;
    assign addr_ok  = (state_q == IDLE);

    // tag compare
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_ways[w] && (way_tag[w] == req_tag);
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit        = |way_hit;
    assign lookup_hit = (state_q == LOOKUP) && hit;
    assign hit_word   = way_line[hit_way][req_offset[OFFSET_W-1:WORD_SEL_LSB]];

    // hit bookkeeping
    assign touch     = lookup_hit;
    assign touch_way = hit_way;

    // word held for the data_ok cycle
    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            rdata <= hit_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= lookup_hit;
        end
    end

    // line request, memory answers in the same cycle
    assign rd_req  = (state_q == MISS);
    assign rd_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};

    // miss buffer
    always_ff @(posedge clk) begin
        if (state_q == MISS) begin
            miss_line <= ret_data;
        end
    end

    // refill into the victim way
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            fill_we[w] = (state_q == REPLACE) && (victim_way == way_t'(w));
        end
    end

    assign tag_we    = fill_we;
    assign data_we   = fill_we;
    assign fill_tag  = req_tag;
    assign fill_line = miss_line;
    assign fill      = (state_q == REPLACE);

    always_comb begin
        case (state_q)
            IDLE: begin
                state_nxt = valid ? LOOKUP : IDLE;
            end
            LOOKUP: begin
                state_nxt = hit ? IDLE : MISS;
            end
            MISS: begin
                state_nxt = REPLACE;
            end
            REPLACE: begin
                // set is read again, write-first gives the new line
                state_nxt = LOOKUP;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    a_rd_req_pulse: assert property (@(posedge clk) disable iff (rst)
        rd_req |=> !rd_req)
        else $error("rd_req longer than one cycle");

    a_data_ok_vs_rd_req: assert property (@(posedge clk) disable iff (rst)
        !(data_ok && rd_req))
        else $error("data_ok together with rd_req");

    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        (state_q == LOOKUP) |-> $onehot0(way_hit))
        else $error("more than one way hit");

endmodule

//--- icache_top.sv
`timescale 1ns/1ns

module icache_top
    import cache_geom_pkg::*;
    import cache_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    // pipeline side
    input  logic    valid,
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,
    // memory side
    output logic    rd_req,
    output addr_t   rd_addr,
    input  line_t   ret_data
);

    index_t          ram_addr;
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] data_we;
    tag_t            fill_tag;
    line_t           fill_line;
    tag_t            way_tag [WAYS];
    line_t           way_line [WAYS];

    logic [WAYS-1:0] valid_ways;
    way_t            victim_way;
    logic            touch;
    way_t            touch_way;
    logic            fill;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .index      (index),
        .tag        (tag),
        .offset     (offset),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .ret_data   (ret_data),
        .ram_addr   (ram_addr),
        .tag_we     (tag_we),
        .data_we    (data_we),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .way_tag    (way_tag),
        .way_line   (way_line),
        .valid_ways (valid_ways),
        .victim_way (victim_way),
        .touch      (touch),
        .touch_way  (touch_way),
        .fill       (fill)
    );

    // one tag RAM and one data RAM per way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_ram #(
            .entry_t (tag_t),
            .DEPTH   (SETS)
        ) u_tag_ram (
            .clk   (clk),
            .addr  (ram_addr),
            .we    (tag_we[w]),
            .wdata (fill_tag),
            .rdata (way_tag[w])
        );

        cache_ram #(
            .entry_t (line_t),
            .DEPTH   (SETS)
        ) u_data_ram (
            .clk   (clk),
            .addr  (ram_addr),
            .we    (data_we[w]),
            .wdata (fill_line),
            .rdata (way_line[w])
        );
    end

    set_state u_set_state (
        .clk        (clk),
        .rst        (rst),
        .addr       (ram_addr),
        .touch      (touch),
        .touch_way  (touch_way),
        .fill       (fill),
        .valid_ways (valid_ways),
        .victim_way (victim_way)
    );

endmodule

//--- tb_icache.sv
`timescale 1ns/1ns

module tb_icache
    import cache_geom_pkg::*;
    import cache_types_pkg::*;
();

    // cycles counted from the acceptance edge
    localparam int HIT_LAT      = 2;
    localparam int MISS_LAT     = 5;
    localparam int RD_REQ_CYCLE = 2;
    localparam int WAIT_LIMIT   = 20;
    localparam int RANDOM_REQS  = 600;

    logic    clk;
    logic    rst;
    logic    valid;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    line_t   ret_data;

    // pending requests, plan_q is -1 where no outcome is planned
    tag_t    tag_q [$];
    index_t  index_q [$];
    offset_t offset_q [$];
    int      plan_q [$];

    logic model_valid [SETS][WAYS];
    tag_t model_tag [SETS][WAYS];
    way_t model_lru [SETS];

    logic [31:0] rng;
    int          hit_count;
    int          miss_count;
    int          evict_count;

    icache_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .index    (index),
        .tag      (tag),
        .offset   (offset),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory content, a hash of the line address
    function automatic word_t mem_word(addr_t line_addr, int w);
        logic [31:0] x;
        x = line_addr ^ (32'h9e37_79b9 * (w + 1));
        x = x ^ (x << 7) ^ (x >> 11);
        x = x * 32'h2c1b_3c6d;
        return x ^ (x >> 15);
    endfunction

    // three tags per set compete for two ways
    function automatic tag_t pool_tag(index_t ix, int k);
        return tag_t'(32'h0002_a5b3 * (k + 1)) ^ tag_t'({ix, 5'b0_0000});
    endfunction

    // memory answers in the same cycle
    assign ret_data = {mem_word(rd_addr, 1), mem_word(rd_addr, 0)};

    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(string what, word_t got, word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_addr(string what, addr_t got, addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_hit(string what, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is a %s, expected a %s",
                $time, what, got ? "hit" : "miss", exp ? "hit" : "miss"));
        end
    endtask

    task automatic check_level(string what, logic got, logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // valid-first victim, else the lru way; any access makes the other way lru
    task automatic model_access(tag_t t, index_t ix, output logic hit);
        int victim;
        hit    = 1'b0;
        victim = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[ix][w] && model_tag[ix][w] == t) begin
                hit           = 1'b1;
                model_lru[ix] = way_t'(1 - w);
            end
        end
        if (!hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (!model_valid[ix][w] && victim < 0) begin
                    victim = w;
                end
            end
            if (victim < 0) begin
                victim = int'(model_lru[ix]);
                evict_count++;
            end
            model_valid[ix][victim] = 1'b1;
            model_tag[ix][victim]   = t;
            model_lru[ix]           = way_t'(1 - victim);
        end
    endtask

    task automatic queue_request(tag_t t, index_t ix, offset_t off, int planned);
        tag_q.push_back(t);
        index_q.push_back(ix);
        offset_q.push_back(off);
        plan_q.push_back(planned);
    endtask

    task automatic drive_head();
        valid  <= 1'b1;
        tag    <= tag_q[0];
        index  <= index_q[0];
        offset <= offset_q[0];
    endtask

    // request already on the inputs, returns on the acceptance edge
    task automatic wait_accept();
        int n;
        n = 0;
        while (!addr_ok) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_with_failure("timeout: addr_ok did not return for a waiting request");
            end
        end
        @(posedge clk);
    endtask

    task automatic collect_response(tag_t t, index_t ix, offset_t off, logic exp_hit,
                                    int planned);
        addr_t line_addr;
        int    lat;
        int    rd_count;
        logic  done;
        line_addr = {t, ix, 3'b000};
        lat       = 0;
        rd_count  = 0;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            lat++;
            if (rd_req) begin
                rd_count++;
                check_addr("rd_addr", rd_addr, line_addr);
                if (lat != RD_REQ_CYCLE) begin
                    stop_with_failure($sformatf("error at %0t ns: rd_req in cycle %0d, expected %0d",
                        $time, lat, RD_REQ_CYCLE));
                end
            end
            if (data_ok) begin
                done = 1'b1;
            end else begin
                check_level("addr_ok while busy", addr_ok, 1'b0);
                if (lat >= WAIT_LIMIT) begin
                    stop_with_failure("timeout: no data_ok for an accepted request");
                end
            end
        end
        check_hit("access against model", lat == HIT_LAT, exp_hit);
        if (planned >= 0) begin
            check_hit("access against planned order", lat == HIT_LAT, planned == 1);
        end
        if (lat != (exp_hit ? HIT_LAT : MISS_LAT)) begin
            stop_with_failure($sformatf("error at %0t ns: data_ok after %0d cycles, expected %0d",
                $time, lat, exp_hit ? HIT_LAT : MISS_LAT));
        end
        if (rd_count != (exp_hit ? 0 : 1)) begin
            stop_with_failure($sformatf("error at %0t ns: %0d rd_req cycles, expected %0d",
                $time, rd_count, exp_hit ? 0 : 1));
        end
        check_level("addr_ok with data_ok", addr_ok, 1'b1);
        check_word("rdata", rdata, mem_word(line_addr, int'(off[2])));
    endtask

    // next request waits on the inputs while the current one is served
    task automatic run_queue();
        tag_t    t;
        index_t  ix;
        offset_t off;
        int      planned;
        logic    exp_hit;
        @(posedge clk);
        drive_head();
        @(negedge clk);
        while (tag_q.size() > 0) begin
            t       = tag_q.pop_front();
            ix      = index_q.pop_front();
            off     = offset_q.pop_front();
            planned = plan_q.pop_front();
            wait_accept();
            if (tag_q.size() > 0) begin
                drive_head();
            end else begin
                valid <= 1'b0;
            end
            model_access(t, ix, exp_hit);
            if (exp_hit) begin
                hit_count++;
            end else begin
                miss_count++;
            end
            collect_response(t, ix, off, exp_hit, planned);
        end
        @(negedge clk);
        check_level("data_ok after its pulse", data_ok, 1'b0);
    endtask

    initial begin
        index_t ix;
        rst    <= 1'b1;
        valid  <= 1'b0;
        index  <= '0;
        tag    <= '0;
        offset <= '0;
        rng    = 32'he4c8;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
            model_lru[s] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_level("addr_ok after reset", addr_ok, 1'b1);
        check_level("data_ok after reset", data_ok, 1'b0);
        check_level("rd_req after reset", rd_req, 1'b0);

        // cold misses, then both words of each line
        queue_request(pool_tag(6'd3, 0), 6'd3, 3'd0, 0);
        queue_request(pool_tag(6'd3, 0), 6'd3, 3'd4, 1);
        queue_request(pool_tag(6'd3, 0), 6'd3, 3'd0, 1);
        queue_request(pool_tag(6'd40, 1), 6'd40, 3'd4, 0);
        queue_request(pool_tag(6'd40, 1), 6'd40, 3'd0, 1);
        run_queue();

        // tag 1 is lru when tag 2 arrives
        queue_request(pool_tag(6'd21, 0), 6'd21, 3'd0, 0);
        queue_request(pool_tag(6'd21, 1), 6'd21, 3'd4, 0);
        queue_request(pool_tag(6'd21, 0), 6'd21, 3'd4, 1);
        queue_request(pool_tag(6'd21, 2), 6'd21, 3'd0, 0);
        queue_request(pool_tag(6'd21, 0), 6'd21, 3'd0, 1);
        queue_request(pool_tag(6'd21, 1), 6'd21, 3'd0, 0);
        queue_request(pool_tag(6'd21, 0), 6'd21, 3'd4, 1);
        run_queue();

        // mostly eight hot sets, now and then any set
        hit_count   = 0;
        miss_count  = 0;
        evict_count = 0;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            rng = xorshift32(rng);
            if (rng[1:0] == 2'b00) begin
                ix = rng[13:8];
            end else begin
                ix = {rng[10:8], 3'b101};
            end
            queue_request(pool_tag(ix, int'(rng[20:16]) % 3), ix, {rng[24], 2'b00}, -1);
        end
        run_queue();

        if (hit_count == 0 || miss_count == 0 || evict_count == 0) begin
            stop_with_failure("random run did not produce hits, misses and evictions");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- src.f
cache_geom_pkg.sv
cache_types_pkg.sv
cache_ram.sv
set_state.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_icache
RTL_TOP   ?= icache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timing --assert

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP) -f $(FILELIST)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "sim: failure reported in $(LOG)"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "sim: run ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
